//--- dp_cfg.svh
`ifndef DP_CFG_SVH
`define DP_CFG_SVH

// --------------------------------------------------
// datapath sizing
// --------------------------------------------------

// width of one data word on the bus
`define DP_WIDTH        32

// memory address width, taken from the low bus bits into MAR
`define DP_ADDR_BITS    9

// general register file
`define DP_NUM_REGS     16
`define DP_REG_IDX_BITS 4

`endif

//--- dpPkg.sv
`default_nettype none

`include "dp_cfg.svh"

package dpPkg;

    // --------------------------------------------------
    // basic data types
    // --------------------------------------------------

    typedef logic [`DP_WIDTH-1:0]        word_t;   // bus, registers, memory data, IR
    typedef logic [`DP_ADDR_BITS-1:0]    addr_t;   // MAR contents
    typedef logic [`DP_REG_IDX_BITS-1:0] regIdx_t; // general register number

    // ALU operations, applied with Y as operand A and the bus as operand B
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,  // a + b
        aluSub   = 4'd1,  // a - b
        aluAnd   = 4'd2,  // a & b
        aluOr    = 4'd3,  // a | b
        aluShr   = 4'd4,  // logical right shift of a
        aluShra  = 4'd5,  // arithmetic right shift of a
        aluShl   = 4'd6,  // left shift of a
        aluRor   = 4'd7,  // rotate a right
        aluRol   = 4'd8,  // rotate a left
        aluNeg   = 4'd9,  // two's complement of b
        aluNot   = 4'd10, // bitwise invert of b
        aluIncPc = 4'd11  // b + 1 for the fetch step
    } aluOp_t;

    // --------------------------------------------------
    // one step of control signals
    // --------------------------------------------------

    typedef struct packed {
        logic    regInEn;   // write a general register from the bus
        regIdx_t regInSel;  // which register is written
        logic    regOutEn;  // drive a general register onto the bus
        regIdx_t regOutSel; // which register is read
        logic    pcIn;      // load PC
        logic    pcOut;     // PC onto bus
        logic    marIn;     // load MAR
        logic    mdrIn;     // load MDR
        logic    mdrOut;    // MDR onto bus
        logic    memRead;   // MDR takes memory data instead of bus
        logic    irIn;      // load IR
        logic    yIn;       // load Y latch
        logic    zIn;       // load Z latch with ALU result
        logic    zOut;      // Z onto bus
        aluOp_t  aluOp;     // operation for this step
    } ctrlWord_t;

endpackage

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ns
`default_nettype none

`include "dp_cfg.svh"

module regFile (
    input  wire logic            clock,
    input  wire logic            rstN,
    input  dpPkg::ctrlWord_t     ctrl,
    input  dpPkg::word_t         bus,
    output dpPkg::word_t         regData
);

    dpPkg::word_t regs [`DP_NUM_REGS]; // R0 .. R15

    // --------------------------------------------------
    // write port from the bus
    // --------------------------------------------------
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `DP_NUM_REGS; i++) begin
                regs[i] <= '0;                          // all registers start at zero
            end
        end else if (ctrl.regInEn) begin
            regs[ctrl.regInSel] <= bus;                 // one write per step
        end
    end

    // read port, always showing the selected register
    // busMux decides if it actually owns the bus
    assign regData = regs[ctrl.regOutSel];

endmodule

`default_nettype wire

//--- specialRegs.sv
`timescale 1ns/1ns
`default_nettype none

`include "dp_cfg.svh"

module specialRegs (
    input  wire logic            clock,
    input  wire logic            rstN,
    input  dpPkg::ctrlWord_t     ctrl,
    input  dpPkg::word_t         bus,
    input  dpPkg::word_t         memDataIn,
    output dpPkg::word_t         pcData,
    output dpPkg::word_t         mdrData,
    output dpPkg::addr_t         marAddr,
    output dpPkg::word_t         irData
);

    dpPkg::word_t pcReg;   // program counter
    dpPkg::word_t irReg;   // instruction register
    dpPkg::addr_t marReg;  // memory address register
    dpPkg::word_t mdrReg;  // memory data register
    dpPkg::word_t mdrNext; // output of the MDR input mux

    // --------------------------------------------------
    // MDR input mux
    // --------------------------------------------------
    always_comb begin
        if (ctrl.memRead) begin
            mdrNext = memDataIn;            // word coming back from memory
        end else begin
            mdrNext = bus;                  // word headed out to memory
        end
    end

    // --------------------------------------------------
    // register updates, each on its own in-enable
    // --------------------------------------------------
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pcReg  <= '0;
            irReg  <= '0;
            marReg <= '0;
            mdrReg <= '0;
        end else begin
            if (ctrl.pcIn)  pcReg  <= bus;                          // jump or incremented PC
            if (ctrl.irIn)  irReg  <= bus;                          // fetched instruction
            if (ctrl.marIn) marReg <= bus[`DP_ADDR_BITS-1:0];       // low address bits only
            if (ctrl.mdrIn) mdrReg <= mdrNext;
        end
    end

    assign pcData  = pcReg;
    assign mdrData = mdrReg;    // bus source and memory write data
    assign marAddr = marReg;
    assign irData  = irReg;     // for the control unit to decode

endmodule

`default_nettype wire

//--- aluUnit.sv
`timescale 1ns/1ns
`default_nettype none

`include "dp_cfg.svh"

module aluUnit (
    input  wire logic            clock,
    input  wire logic            rstN,
    input  dpPkg::ctrlWord_t     ctrl,
    input  dpPkg::word_t         bus,
    output dpPkg::word_t         zData
);

    dpPkg::word_t                yReg;      // operand A latch
    dpPkg::word_t                zReg;      // result latch
    dpPkg::word_t                aluResult; // combinational result
    logic [4:0]                  shAmt;     // shift / rotate amount
    logic [2*`DP_WIDTH-1:0]      rorWide;   // doubled A shifted right
    logic [2*`DP_WIDTH-1:0]      rolWide;   // doubled A shifted left

    // --------------------------------------------------
    // operand A latch
    // --------------------------------------------------
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            yReg <= '0;
        end else if (ctrl.yIn) begin
            yReg <= bus;                    // A is taken a step ahead of B
        end
    end

    assign shAmt = bus[4:0];                // only the low five bits count

    // rotates via a doubled word so bits wrap within 32
    assign rorWide = {yReg, yReg} >> shAmt;
    assign rolWide = {yReg, yReg} << shAmt;

    // --------------------------------------------------
    // combinational ALU, A from Y and B from the bus
    // --------------------------------------------------
    always_comb begin
        case (ctrl.aluOp)
            dpPkg::aluAdd:   aluResult = yReg + bus;
            dpPkg::aluSub:   aluResult = yReg - bus;
            dpPkg::aluAnd:   aluResult = yReg & bus;
            dpPkg::aluOr:    aluResult = yReg | bus;
            dpPkg::aluShr:   aluResult = yReg >> shAmt;            // zero fill
            dpPkg::aluShra:  aluResult = $signed(yReg) >>> shAmt;  // sign of Y kept
            dpPkg::aluShl:   aluResult = yReg << shAmt;
            dpPkg::aluRor:   aluResult = rorWide[`DP_WIDTH-1:0];
            dpPkg::aluRol:   aluResult = rolWide[2*`DP_WIDTH-1:`DP_WIDTH];
            dpPkg::aluNeg:   aluResult = ~bus + dpPkg::word_t'(1);  // B alone
            dpPkg::aluNot:   aluResult = ~bus;                      // B alone
            dpPkg::aluIncPc: aluResult = bus + dpPkg::word_t'(1);  // PC + 1 in fetch
            default:         aluResult = '0;                        // unused codes
        endcase
    end

    // --------------------------------------------------
    // result latch
    // --------------------------------------------------
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            zReg <= '0;
        end else if (ctrl.zIn) begin
            zReg <= aluResult;              // readable on the bus next step
        end
    end

    assign zData = zReg;

endmodule

`default_nettype wire

//--- busMux.sv
`timescale 1ns/1ns
`default_nettype none

module busMux (
    input  dpPkg::ctrlWord_t     ctrl,
    input  dpPkg::word_t         regData,
    input  dpPkg::word_t         pcData,
    input  dpPkg::word_t         mdrData,
    input  dpPkg::word_t         zData,
    output dpPkg::word_t         bus
);

    // one owner per step
    typedef enum logic [2:0] {
        srcNone,    // bus idles at zero
        srcZ,
        srcMdr,
        srcPc,
        srcReg
    } busSrc_t;

    busSrc_t busSrc;

    // fixed priority encode, zOut wins over everything
    always_comb begin
        if (ctrl.zOut)          busSrc = srcZ;
        else if (ctrl.mdrOut)   busSrc = srcMdr;
        else if (ctrl.pcOut)    busSrc = srcPc;
        else if (ctrl.regOutEn) busSrc = srcReg;
        else                    busSrc = srcNone;
    end

    always_comb begin
        case (busSrc)
            srcZ:    bus = zData;
            srcMdr:  bus = mdrData;
            srcPc:   bus = pcData;
            srcReg:  bus = regData;
            default: bus = '0;      // nobody driving
        endcase
    end

endmodule

`default_nettype wire

//--- dataPath.sv
`timescale 1ns/1ns
`default_nettype none

module dataPath (
    input  wire logic            clock,
    input  wire logic            rstN,
    input  dpPkg::ctrlWord_t     ctrl,
    input  dpPkg::word_t         memDataIn,
    output dpPkg::addr_t         marAddr,
    output dpPkg::word_t         mdrData,
    output dpPkg::word_t         irData
);

    dpPkg::word_t bus;      // the single shared bus
    dpPkg::word_t regData;  // selected general register
    dpPkg::word_t pcData;   // program counter
    dpPkg::word_t zData;    // ALU result latch

    // --------------------------------------------------
    // bus sources and loaders
    // --------------------------------------------------
    regFile uRegFile (
        .clock   (clock),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .bus     (bus),
        .regData (regData)
    );

    specialRegs uSpecialRegs (
        .clock     (clock),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .bus       (bus),
        .memDataIn (memDataIn),     // straight from memory
        .pcData    (pcData),
        .mdrData   (mdrData),       // also the memory write word
        .marAddr   (marAddr),       // memory address out
        .irData    (irData)         // to the control unit
    );

    aluUnit uAluUnit (
        .clock (clock),
        .rstN  (rstN),
        .ctrl  (ctrl),
        .bus   (bus),
        .zData (zData)
    );

    // --------------------------------------------------
    // bus ownership
    // --------------------------------------------------
    busMux uBusMux (
        .ctrl    (ctrl),
        .regData (regData),
        .pcData  (pcData),
        .mdrData (mdrData),
        .zData   (zData),
        .bus     (bus)
    );

endmodule

`default_nettype wire

//--- dataPathTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "dp_cfg.svh"

module dataPathTb;

    logic             clock;
    logic             rstN;
    dpPkg::ctrlWord_t ctrl;            // one control word per step
    dpPkg::word_t     memDataIn;       // plays the memory read data
    dpPkg::addr_t     marAddr;
    dpPkg::word_t     mdrData;
    dpPkg::word_t     irData;
    int unsigned      cycleCount = 0;  // rising edges seen so far
    logic [31:0]      lcgState;        // random generator state

    dataPath dut (
        .clock     (clock),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .memDataIn (memDataIn),
        .marAddr   (marAddr),
        .mdrData   (mdrData),
        .irData    (irData)
    );

    always #2 clock = ~clock;                         // 4 ns period

    always @(posedge clock) cycleCount <= cycleCount + 1;

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkWord(input string name, input dpPkg::word_t exp, input dpPkg::word_t act);
        if (exp !== act) begin
            failRun($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic checkAddr(input string name, input dpPkg::addr_t exp, input dpPkg::addr_t act);
        if (exp !== act) begin
            failRun($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    // drive one word at a falling edge, hold it across one rising edge
    task automatic applyStep(input dpPkg::ctrlWord_t cw);
        int unsigned startCount;
        int          guard;
        startCount = cycleCount;
        guard      = 0;
        ctrl       = cw;
        while (cycleCount == startCount && guard < 8) begin
            @(negedge clock);
            guard++;
        end
        ctrl = '0;                                    // back to idle
        if (cycleCount == startCount) failRun("control step did not complete before the timeout");
    endtask

    task automatic loadReg(input dpPkg::regIdx_t idx, input dpPkg::word_t val);
        dpPkg::ctrlWord_t cw;
        memDataIn  = val;
        cw         = '0;
        cw.memRead = 1'b1;                            // memory word into MDR
        cw.mdrIn   = 1'b1;
        applyStep(cw);
        cw          = '0;
        cw.mdrOut   = 1'b1;                           // then MDR into the register
        cw.regInEn  = 1'b1;
        cw.regInSel = idx;
        applyStep(cw);
    endtask

    task automatic readReg(input dpPkg::regIdx_t idx, output dpPkg::word_t val);
        dpPkg::ctrlWord_t cw;
        cw           = '0;
        cw.regOutEn  = 1'b1;
        cw.regOutSel = idx;
        cw.mdrIn     = 1'b1;                          // memRead clear so the bus wins
        applyStep(cw);
        val = mdrData;
    endtask

    // expected ALU result straight from the operation rules
    function automatic dpPkg::word_t aluModel(input dpPkg::aluOp_t op,
                                              input dpPkg::word_t a, input dpPkg::word_t b);
        dpPkg::word_t r;
        int           n;
        n = b[4:0];                                   // amount from low five bits of B
        r = a;
        case (op)
            dpPkg::aluAdd:   r = a + b;
            dpPkg::aluSub:   r = a - b;
            dpPkg::aluAnd:   r = a & b;
            dpPkg::aluOr:    r = a | b;
            dpPkg::aluShr:   r = a >> n;
            dpPkg::aluShra:  for (int k = 0; k < n; k++) r = {a[`DP_WIDTH-1], r[`DP_WIDTH-1:1]};
            dpPkg::aluShl:   r = a << n;
            dpPkg::aluRor:   for (int k = 0; k < n; k++) r = {r[0], r[`DP_WIDTH-1:1]};
            dpPkg::aluRol:   for (int k = 0; k < n; k++) r = {r[`DP_WIDTH-2:0], r[`DP_WIDTH-1]};
            dpPkg::aluNeg:   r = 32'd0 - b;
            dpPkg::aluNot:   r = ~b;
            dpPkg::aluIncPc: r = b + 32'd1;
            default:         r = '0;
        endcase
        return r;
    endfunction

    // Ra=R1 into Y, Rb=R2 on the bus with zIn, Z into Rc=R3, read Rc back
    task automatic runAlu(input dpPkg::aluOp_t op, input dpPkg::word_t a,
                          input dpPkg::word_t b, output dpPkg::word_t res);
        dpPkg::ctrlWord_t cw;
        loadReg(4'd1, a);
        loadReg(4'd2, b);
        cw           = '0;
        cw.regOutEn  = 1'b1;
        cw.regOutSel = 4'd1;
        cw.yIn       = 1'b1;
        applyStep(cw);
        cw           = '0;
        cw.regOutEn  = 1'b1;
        cw.regOutSel = 4'd2;
        cw.zIn       = 1'b1;
        cw.aluOp     = op;
        applyStep(cw);
        cw          = '0;
        cw.zOut     = 1'b1;
        cw.regInEn  = 1'b1;
        cw.regInSel = 4'd3;
        applyStep(cw);
        readReg(4'd3, res);
    endtask

    task automatic fetchOnce(input dpPkg::word_t instr, input dpPkg::word_t oldPc, input string name);
        dpPkg::ctrlWord_t cw;
        cw       = '0;
        cw.pcOut = 1'b1;                              // T0
        cw.marIn = 1'b1;
        cw.zIn   = 1'b1;
        cw.aluOp = dpPkg::aluIncPc;
        applyStep(cw);
        checkAddr({name, " mar"}, oldPc[`DP_ADDR_BITS-1:0], marAddr);
        memDataIn  = instr;
        cw         = '0;
        cw.zOut    = 1'b1;                            // T1
        cw.pcIn    = 1'b1;
        cw.memRead = 1'b1;
        cw.mdrIn   = 1'b1;
        applyStep(cw);
        cw        = '0;
        cw.mdrOut = 1'b1;                             // T2
        cw.irIn   = 1'b1;
        applyStep(cw);
        checkWord({name, " ir"}, instr, irData);
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic testReset();
        dpPkg::word_t val;
        checkAddr("reset mar", '0, marAddr);
        checkWord("reset mdr", '0, mdrData);
        checkWord("reset ir", '0, irData);
        for (int i = 0; i < `DP_NUM_REGS; i++) begin
            readReg(dpPkg::regIdx_t'(i), val);
            checkWord($sformatf("reset R%0d", i), '0, val);
        end
    endtask

    task automatic testRegLoad();
        dpPkg::word_t vals [`DP_NUM_REGS];
        dpPkg::word_t val;
        for (int i = 0; i < `DP_NUM_REGS; i++) begin
            vals[i] = nextRand();
            loadReg(dpPkg::regIdx_t'(i), vals[i]);
        end
        for (int i = 0; i < `DP_NUM_REGS; i++) begin   // all written before any read
            readReg(dpPkg::regIdx_t'(i), val);
            checkWord($sformatf("readback R%0d", i), vals[i], val);
        end
    endtask

    task automatic testFetch();
        dpPkg::ctrlWord_t cw;
        fetchOnce(nextRand(), 32'd0, "fetch 1");      // PC untouched since reset
        fetchOnce(nextRand(), 32'd1, "fetch 2");
        loadReg(4'd5, 32'h0000_01ff);
        cw           = '0;
        cw.regOutEn  = 1'b1;                          // jump to top of address space
        cw.regOutSel = 4'd5;
        cw.pcIn      = 1'b1;
        applyStep(cw);
        fetchOnce(nextRand(), 32'h0000_01ff, "fetch 3");
        fetchOnce(nextRand(), 32'h0000_0200, "fetch 4"); // mar keeps low bits only
    endtask

    task automatic testAlu();
        dpPkg::aluOp_t op;
        dpPkg::word_t  a;
        dpPkg::word_t  b;
        dpPkg::word_t  res;
        for (int k = 0; k < 12; k++) begin
            op = dpPkg::aluOp_t'(k);
            a  = nextRand();
            b  = nextRand();
            runAlu(op, a, b, res);
            checkWord($sformatf("alu op %0d", k), aluModel(op, a, b), res);
        end
        runAlu(dpPkg::aluShr, 32'h12, 32'd4, res);
        checkWord("alu shr reference", 32'h1, res);
        runAlu(dpPkg::aluShra, 32'h8000_00f0, 32'h24, res); // negative A, amount 4
        checkWord("alu shra negative", aluModel(dpPkg::aluShra, 32'h8000_00f0, 32'h24), res);
    endtask

    task automatic testBusOwner();
        dpPkg::ctrlWord_t cw;
        dpPkg::word_t     zVal;
        dpPkg::word_t     rVal;
        memDataIn  = nextRand() | 32'h1;              // make MDR nonzero first
        cw         = '0;
        cw.memRead = 1'b1;
        cw.mdrIn   = 1'b1;
        applyStep(cw);
        cw       = '0;
        cw.mdrIn = 1'b1;                              // nobody drives the bus
        applyStep(cw);
        checkWord("bus idle", '0, mdrData);
        zVal = nextRand();
        rVal = nextRand();
        loadReg(4'd4, zVal);
        loadReg(4'd6, rVal);
        cw           = '0;
        cw.regOutEn  = 1'b1;
        cw.regOutSel = 4'd4;
        cw.zIn       = 1'b1;
        cw.aluOp     = dpPkg::aluIncPc;               // Z = R4 + 1
        applyStep(cw);
        cw           = '0;
        cw.zOut      = 1'b1;
        cw.regOutEn  = 1'b1;
        cw.regOutSel = 4'd6;
        cw.mdrIn     = 1'b1;
        applyStep(cw);
        checkWord("bus z over reg", zVal + 32'd1, mdrData);
        cw.zOut = 1'b0;
        applyStep(cw);
        checkWord("bus reg alone", rVal, mdrData);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        int guard;
        clock     = 1'b0;
        rstN      = 1'b0;
        ctrl      = '0;
        memDataIn = '0;
        lcgState  = 32'hf13f_5a83;
        guard     = 0;
        while (cycleCount < 5 && guard < 40) begin    // hold reset for 5 cycles
            @(negedge clock);
            guard++;
        end
        if (cycleCount < 5) failRun("reset did not complete before the timeout");
        rstN = 1'b1;
        testReset();
        testRegLoad();
        testFetch();
        testAlu();
        testBusOwner();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
dpPkg.sv
regFile.sv
specialRegs.sv
aluUnit.sv
busMux.sv
dataPath.sv
dataPathTb.sv
